//--- cpu_pkg.sv
`default_nettype none

package cpu_pkg;

	// Load opcodes keep the RISC-V funct3 values; stores fill the free codes.
	typedef enum logic [2:0] {
		MEM_LB  = 3'd0,
		MEM_LH  = 3'd1,
		MEM_LW  = 3'd2,
		MEM_SB  = 3'd3,
		MEM_LBU = 3'd4,
		MEM_LHU = 3'd5,
		MEM_SH  = 3'd6,
		MEM_SW  = 3'd7
	} mem_op_e;

	typedef enum logic [2:0] {
		SEL_ALU = 3'd0,
		SEL_MEM = 3'd1,
		SEL_CSR = 3'd2,
		SEL_FPU = 3'd3,
		SEL_PC4 = 3'd4
	} wb_src_e;

	// The bus error code sits in the custom-use range of mcause.
	typedef enum logic [31:0] {
		CAUSE_NONE             = 32'd0,
		CAUSE_ILLEGAL_INSN     = 32'd2,
		CAUSE_BREAKPOINT       = 32'd3,
		CAUSE_LOAD_MISALIGNED  = 32'd4,
		CAUSE_STORE_MISALIGNED = 32'd6,
		CAUSE_ECALL_U          = 32'd8,
		CAUSE_ECALL_M          = 32'd11,
		CAUSE_DMEM_BUS_ERROR   = 32'd24
	} exc_cause_e;

	// A store is a SEL_MEM bundle with rd_wena low.
	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] ir;
		logic [31:0] imm;
		logic        rd_wena;
		logic [5:0]  rd_addr;
		logic [31:0] rd_data;
		logic [31:0] mem_addr;
		logic [31:0] store_data;
		mem_op_e     mem_op;
		wb_src_e     wb_src;
		logic [11:0] csr_addr;
		logic        csr_rena;
		logic        csr_wena;
		logic [31:0] csr_wdata;
		logic [1:0]  csr_op;
		logic [4:0]  fpu_flags;
		logic        trap_ret;
		logic        exc_pend;
		exc_cause_e  exc_cause;
	} ex_bundle_t;

	typedef struct packed {
		ex_bundle_t ex;
		logic       bus_access;
	} req_bundle_t;

	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] ir;
		logic [31:0] imm;
		logic        rd_wena;
		logic [5:0]  rd_addr;
		logic [31:0] rd_data;
		wb_src_e     wb_src;
		logic [11:0] csr_addr;
		logic        csr_rena;
		logic        csr_wena;
		logic [31:0] csr_wdata;
		logic [1:0]  csr_op;
		logic [4:0]  fpu_flags;
		logic        trap_ret;
		logic        exc_pend;
		exc_cause_e  exc_cause;
	} mem_bundle_t;

endpackage

`default_nettype wire

//--- dmem_bus_pkg.sv
`default_nettype none

package dmem_bus_pkg;

	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_EXOKAY = 2'b01,
		RESP_SLVERR = 2'b10,
		RESP_DECERR = 2'b11
	} axi_resp_e;

	// Read address channel.
	typedef struct packed {
		logic [31:0] addr;
	} axi_ar_t;

	// Write address channel.
	typedef struct packed {
		logic [31:0] addr;
	} axi_aw_t;

	typedef struct packed {
		logic [31:0] data;
		logic [3:0]  strb;
	} axi_w_t;

	typedef struct packed {
		logic [31:0] data;
		axi_resp_e   resp;
	} axi_r_t;

	typedef struct packed {
		axi_resp_e resp;
	} axi_b_t;

endpackage

`default_nettype wire

//--- dmem_request.sv
`timescale 1ns/1ns
`default_nettype none

module dmem_request import cpu_pkg::*, dmem_bus_pkg::*; (
	input  logic        clk,
	input  logic        reset,

	input  logic        ex_valid,
	output logic        ex_ready,
	input  ex_bundle_t  ex_bundle,

	output logic        req_valid,
	input  logic        req_ready,
	output req_bundle_t req_bundle,

	output logic        ar_valid,
	input  logic        ar_ready,
	output axi_ar_t     ar,
	output logic        aw_valid,
	input  logic        aw_ready,
	output axi_aw_t     aw,
	output logic        w_valid,
	input  logic        w_ready,
	output axi_w_t      w
);

	logic        out_of_reset;
	logic        is_mem;
	logic        is_store;
	logic        misaligned;
	logic        do_access;
	logic        bus_wait;
	logic        ex_fire;
	logic        req_fire;
	logic [31:0] lane_data;
	logic [3:0]  lane_strb;

	assign is_mem    = ex_bundle.wb_src == SEL_MEM && !ex_bundle.exc_pend;
	assign is_store  = !ex_bundle.rd_wena;
	assign do_access = is_mem && !misaligned;

	// A bus request of our own that is not yet taken blocks the next bundle.
	assign bus_wait = (ar_valid && !ar_ready) || (aw_valid && !aw_ready) ||
		(w_valid && !w_ready);
	assign ex_ready = out_of_reset && (!req_valid || req_ready) && !bus_wait;
	assign ex_fire  = ex_valid && ex_ready;
	assign req_fire = req_valid && req_ready;

	assign ar.addr = req_bundle.ex.mem_addr;
	assign aw.addr = req_bundle.ex.mem_addr;

	always_comb begin
		case (ex_bundle.mem_op)
			MEM_LH, MEM_LHU, MEM_SH: misaligned = ex_bundle.mem_addr[0];
			MEM_LW, MEM_SW:          misaligned = |ex_bundle.mem_addr[1:0];
			default:                 misaligned = 1'b0;
		endcase
	end

	// Narrow stores are copied to every lane; the strobe picks the one that counts.
	always_comb begin
		case (ex_bundle.mem_op)
			MEM_SB: begin
				lane_data = {4{ex_bundle.store_data[7:0]}};
				lane_strb = 4'b0001 << ex_bundle.mem_addr[1:0];
			end
			MEM_SH: begin
				lane_data = {2{ex_bundle.store_data[15:0]}};
				lane_strb = 4'b0011 << {ex_bundle.mem_addr[1], 1'b0};
			end
			MEM_SW: begin
				lane_data = ex_bundle.store_data;
				lane_strb = 4'b1111;
			end
			default: begin
				lane_data = ex_bundle.store_data;
				lane_strb = 4'b0000;
			end
		endcase
	end

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			out_of_reset <= 1'b0;
			req_valid    <= 1'b0;
			ar_valid     <= 1'b0;
			aw_valid     <= 1'b0;
			w_valid      <= 1'b0;
		end else begin
			out_of_reset <= 1'b1;
			if (ar_valid && ar_ready)
				ar_valid <= 1'b0;
			if (aw_valid && aw_ready)
				aw_valid <= 1'b0;
			if (w_valid && w_ready)
				w_valid <= 1'b0;
			if (ex_fire) begin
				req_valid <= 1'b1;
				ar_valid  <= do_access && !is_store;
				aw_valid  <= do_access && is_store;
				w_valid   <= do_access && is_store;
			end else if (req_fire) begin
				req_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (ex_fire) begin
			req_bundle.ex         <= ex_bundle;
			req_bundle.bus_access <= do_access;
			w.data                <= lane_data;
			w.strb                <= lane_strb;
			if (is_mem && misaligned) begin
				req_bundle.ex.exc_pend <= 1'b1;
				if (is_store)
					req_bundle.ex.exc_cause <= CAUSE_STORE_MISALIGNED;
				else
					req_bundle.ex.exc_cause <= CAUSE_LOAD_MISALIGNED;
			end
		end
	end

endmodule

`default_nettype wire

//--- data_ram.sv
`timescale 1ns/1ns
`default_nettype none

module data_ram import dmem_bus_pkg::*; #(
	parameter int dmem_words = 256
) (
	input  logic    clk,
	input  logic    reset,

	input  logic    ar_valid,
	output logic    ar_ready,
	input  axi_ar_t ar,
	input  logic    aw_valid,
	output logic    aw_ready,
	input  axi_aw_t aw,
	input  logic    w_valid,
	output logic    w_ready,
	input  axi_w_t  w,

	output logic    r_valid,
	input  logic    r_ready,
	output axi_r_t  r,
	output logic    b_valid,
	input  logic    b_ready,
	output axi_b_t  b
);

	localparam int idx_w = $clog2(dmem_words);

	logic [31:0]      mem [dmem_words];
	logic             busy;
	logic             rd_hit;
	logic             wr_hit;
	logic [idx_w-1:0] rd_idx;
	logic [idx_w-1:0] wr_idx;

	// Only one response is held at a time, so requests wait while one is pending.
	assign busy     = r_valid || b_valid;
	assign aw_ready = aw_valid && w_valid && !busy;
	assign w_ready  = aw_ready;
	assign ar_ready = ar_valid && !busy && !aw_ready;

	assign rd_hit = ar.addr[31:2] < 30'(dmem_words);
	assign wr_hit = aw.addr[31:2] < 30'(dmem_words);
	assign rd_idx = ar.addr[idx_w+1:2];
	assign wr_idx = aw.addr[idx_w+1:2];

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			r_valid <= 1'b0;
			b_valid <= 1'b0;
		end else begin
			if (ar_ready)
				r_valid <= 1'b1;
			else if (r_ready)
				r_valid <= 1'b0;
			if (aw_ready)
				b_valid <= 1'b1;
			else if (b_ready)
				b_valid <= 1'b0;
		end
	end

	// Writes outside the array are dropped.
	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			for (int i = 0; i < dmem_words; i++)
				mem[i] <= '0;
		end else if (aw_ready && wr_hit) begin
			for (int i = 0; i < 4; i++)
				if (w.strb[i])
					mem[wr_idx][8*i +: 8] <= w.data[8*i +: 8];
		end
	end

	always_ff @(posedge clk) begin
		if (ar_ready) begin
			if (rd_hit) begin
				r.data <= mem[rd_idx];
				r.resp <= RESP_OKAY;
			end else begin
				r.data <= '0;
				r.resp <= RESP_SLVERR;
			end
		end
		if (aw_ready) begin
			if (wr_hit)
				b.resp <= RESP_OKAY;
			else
				b.resp <= RESP_SLVERR;
		end
	end

endmodule

`default_nettype wire

//--- mem_stage.sv
`timescale 1ns/1ns
`default_nettype none

module mem_stage import cpu_pkg::*, dmem_bus_pkg::*; (
	input  logic        clk,
	input  logic        reset,

	input  logic        req_valid,
	output logic        req_ready,
	input  req_bundle_t req_bundle,

	input  logic        r_valid,
	output logic        r_ready,
	input  axi_r_t      r,
	input  logic        b_valid,
	output logic        b_ready,
	input  axi_b_t      b,

	output logic        out_valid,
	input  logic        out_ready,
	output mem_bundle_t out_bundle
);

	ex_bundle_t  ex;
	logic        is_load;
	logic        needs_resp;
	logic        resp_here;
	logic        resp_ok;
	logic        csr_hold;
	logic        stall;
	logic        req_fire;
	logic [1:0]  offset;
	logic [7:0]  ld_byte;
	logic [15:0] ld_half;
	mem_bundle_t nxt;

	assign ex         = req_bundle.ex;
	assign is_load    = ex.rd_wena;
	assign needs_resp = req_bundle.bus_access;
	assign resp_here  = is_load ? r_valid : b_valid;
	assign resp_ok    = is_load ? r.resp == RESP_OKAY : b.resp == RESP_OKAY;

	// A CSR access in the register must reach write-back before the next bundle.
	assign csr_hold  = out_valid && (out_bundle.csr_rena || out_bundle.csr_wena);
	assign stall     = csr_hold || (req_valid && needs_resp && !resp_here);
	assign req_ready = out_ready && !stall;
	assign req_fire  = req_valid && req_ready;

	assign r_ready = req_fire && needs_resp && is_load;
	assign b_ready = req_fire && needs_resp && !is_load;

	// Whole byte lanes are picked from the address kept in the bundle.
	assign offset  = ex.mem_addr[1:0];
	assign ld_byte = r.data[8*offset +: 8];
	assign ld_half = offset[1] ? r.data[31:16] : r.data[15:0];

	always_comb begin
		nxt.pc        = ex.pc;
		nxt.ir        = ex.ir;
		nxt.imm       = ex.imm;
		nxt.rd_wena   = ex.rd_wena;
		nxt.rd_addr   = ex.rd_addr;
		nxt.rd_data   = ex.rd_data;
		nxt.wb_src    = ex.wb_src;
		nxt.csr_addr  = ex.csr_addr;
		nxt.csr_rena  = ex.csr_rena;
		nxt.csr_wena  = ex.csr_wena;
		nxt.csr_wdata = ex.csr_wdata;
		nxt.csr_op    = ex.csr_op;
		nxt.fpu_flags = ex.fpu_flags;
		nxt.trap_ret  = ex.trap_ret;
		nxt.exc_pend  = ex.exc_pend;
		nxt.exc_cause = ex.exc_cause;

		if (needs_resp) begin
			if (!resp_ok) begin
				nxt.rd_wena   = 1'b0;
				nxt.csr_wena  = 1'b0;
				nxt.exc_pend  = 1'b1;
				nxt.exc_cause = CAUSE_DMEM_BUS_ERROR;
			end else if (is_load) begin
				case (ex.mem_op)
					MEM_LB:  nxt.rd_data = {{24{ld_byte[7]}}, ld_byte};
					MEM_LBU: nxt.rd_data = {24'h000000, ld_byte};
					MEM_LH:  nxt.rd_data = {{16{ld_half[15]}}, ld_half};
					MEM_LHU: nxt.rd_data = {16'h0000, ld_half};
					default: nxt.rd_data = r.data;
				endcase
			end
		end
	end

	// MEM/WB register.
	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			out_valid  <= 1'b0;
			out_bundle <= '0;
		end else if (req_fire) begin
			out_valid  <= 1'b1;
			out_bundle <= nxt;
		end else if (out_valid && out_ready) begin
			out_valid  <= 1'b0;
			out_bundle <= '0;
		end
	end

endmodule

`default_nettype wire

//--- mem_subsystem.sv
`timescale 1ns/1ns
`default_nettype none

module mem_subsystem import cpu_pkg::*, dmem_bus_pkg::*; #(
	parameter int dmem_words = 256
) (
	input  logic        clk,
	input  logic        reset,

	input  logic        ex_valid,
	output logic        ex_ready,
	input  ex_bundle_t  ex_bundle,

	output logic        out_valid,
	input  logic        out_ready,
	output mem_bundle_t out_bundle
);

	logic        req_valid;
	logic        req_ready;
	req_bundle_t req_bundle;

	logic        ar_valid;
	logic        ar_ready;
	axi_ar_t     ar;
	logic        aw_valid;
	logic        aw_ready;
	axi_aw_t     aw;
	logic        w_valid;
	logic        w_ready;
	axi_w_t      w;
	logic        r_valid;
	logic        r_ready;
	axi_r_t      r;
	logic        b_valid;
	logic        b_ready;
	axi_b_t      b;

	dmem_request u_request (
		.clk, .reset,
		.ex_valid, .ex_ready, .ex_bundle,
		.req_valid, .req_ready, .req_bundle,
		.ar_valid, .ar_ready, .ar,
		.aw_valid, .aw_ready, .aw,
		.w_valid, .w_ready, .w
	);

	data_ram #(
		.dmem_words(dmem_words)
	) u_ram (
		.clk, .reset,
		.ar_valid, .ar_ready, .ar,
		.aw_valid, .aw_ready, .aw,
		.w_valid, .w_ready, .w,
		.r_valid, .r_ready, .r,
		.b_valid, .b_ready, .b
	);

	mem_stage u_mem (
		.clk, .reset,
		.req_valid, .req_ready, .req_bundle,
		.r_valid, .r_ready, .r,
		.b_valid, .b_ready, .b,
		.out_valid, .out_ready, .out_bundle
	);

endmodule

`default_nettype wire

//--- tb_mem_subsystem.sv
`timescale 1ns/1ns
`default_nettype none

module tb_mem_subsystem import cpu_pkg::*; ();

	localparam int dmem_words = 256;

	logic        clk;
	logic        reset;
	logic        ex_valid;
	logic        ex_ready;
	ex_bundle_t  ex_bundle;
	logic        out_valid;
	logic        out_ready;
	mem_bundle_t out_bundle;

	string       names[$];
	ex_bundle_t  stim[$];
	exc_cause_e  causes[$];
	int          n_tests = 0;
	logic [31:0] model_mem [dmem_words];
	logic [15:0] lfsr_state = 16'd5079;

	mem_subsystem #(
		.dmem_words(dmem_words)
	) dut (
		.clk, .reset,
		.ex_valid, .ex_ready, .ex_bundle,
		.out_valid, .out_ready, .out_bundle
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic logic random_bit();
		logic out_bit;
		out_bit = lfsr_state[0];
		lfsr_state = lfsr_state >> 1;
		if (out_bit)
			lfsr_state = lfsr_state ^ 16'hB400;
		return out_bit;
	endfunction

	task automatic abort_run(string msg);
		$display("%s", msg);
		$display("CHECKS FAILED");
		$fatal(1, "run stopped");
	endtask

	task automatic check_bundle(string name, mem_bundle_t expected, mem_bundle_t actual);
		if (actual !== expected) begin
			$display("ERROR %s: expected %h, actual %h", name, expected, actual);
			$display("CHECKS FAILED");
			$fatal(1, "bundle mismatch");
		end
	endtask

	task automatic check_cause(string name, exc_cause_e expected, exc_cause_e actual);
		if (actual !== expected) begin
			$display("ERROR %s: expected %s, actual %s", name, expected.name(), actual.name());
			$display("CHECKS FAILED");
			$fatal(1, "cause mismatch");
		end
	endtask

	task automatic check_word(string name, logic [31:0] expected, logic [31:0] actual);
		if (actual !== expected) begin
			$display("ERROR %s: expected %h, actual %h", name, expected, actual);
			$display("CHECKS FAILED");
			$fatal(1, "load data mismatch");
		end
	endtask

	// Expected MEM/WB bundle for one entry, taken in program order.
	function automatic mem_bundle_t model_step(ex_bundle_t e);
		mem_bundle_t m;
		logic [31:0] word;
		logic [7:0]  bval;
		logic [15:0] hval;
		logic        store;
		logic        bad_align;
		m.pc        = e.pc;
		m.ir        = e.ir;
		m.imm       = e.imm;
		m.rd_wena   = e.rd_wena;
		m.rd_addr   = e.rd_addr;
		m.rd_data   = e.rd_data;
		m.wb_src    = e.wb_src;
		m.csr_addr  = e.csr_addr;
		m.csr_rena  = e.csr_rena;
		m.csr_wena  = e.csr_wena;
		m.csr_wdata = e.csr_wdata;
		m.csr_op    = e.csr_op;
		m.fpu_flags = e.fpu_flags;
		m.trap_ret  = e.trap_ret;
		m.exc_pend  = e.exc_pend;
		m.exc_cause = e.exc_cause;
		if (e.wb_src != SEL_MEM || e.exc_pend)
			return m;
		store = !e.rd_wena;
		bad_align = ((e.mem_op inside {MEM_LH, MEM_LHU, MEM_SH}) && e.mem_addr[0]) ||
			((e.mem_op inside {MEM_LW, MEM_SW}) && e.mem_addr[1:0] != 2'b00);
		if (bad_align) begin
			m.exc_pend  = 1'b1;
			m.exc_cause = store ? CAUSE_STORE_MISALIGNED : CAUSE_LOAD_MISALIGNED;
		end else if (e.mem_addr >= 32'(dmem_words * 4)) begin
			m.rd_wena   = 1'b0;
			m.csr_wena  = 1'b0;
			m.exc_pend  = 1'b1;
			m.exc_cause = CAUSE_DMEM_BUS_ERROR;
		end else begin
			word = model_mem[e.mem_addr[9:2]];
			if (store) begin
				case (e.mem_op)
					MEM_SB:  word[8*e.mem_addr[1:0] +: 8] = e.store_data[7:0];
					MEM_SH:  word[16*e.mem_addr[1] +: 16] = e.store_data[15:0];
					default: word = e.store_data;
				endcase
				model_mem[e.mem_addr[9:2]] = word;
			end else begin
				bval = word[8*e.mem_addr[1:0] +: 8];
				hval = e.mem_addr[1] ? word[31:16] : word[15:0];
				case (e.mem_op)
					MEM_LB:  m.rd_data = {{24{bval[7]}}, bval};
					MEM_LBU: m.rd_data = {24'h000000, bval};
					MEM_LH:  m.rd_data = {{16{hval[15]}}, hval};
					MEM_LHU: m.rd_data = {16'h0000, hval};
					default: m.rd_data = word;
				endcase
			end
		end
		return m;
	endfunction

	function automatic ex_bundle_t plain_bundle(wb_src_e src);
		ex_bundle_t e;
		e = '0;
		e.pc        = 32'h0000_1000 + 32'(4 * names.size());
		e.ir        = {16'hA5C3, 16'(names.size())};
		e.imm       = 32'hFFFF_FFF0;
		e.rd_wena   = 1'b1;
		e.rd_addr   = 6'(names.size());
		e.rd_data   = 32'h5A5A_0000 | 32'(names.size());
		e.mem_op    = MEM_LW;
		e.wb_src    = src;
		e.exc_cause = CAUSE_NONE;
		return e;
	endfunction

	function automatic ex_bundle_t mem_access(mem_op_e op, logic [31:0] addr, logic [31:0] data);
		ex_bundle_t e;
		e = plain_bundle(SEL_MEM);
		e.mem_op     = op;
		e.mem_addr   = addr;
		e.store_data = data;
		e.rd_wena    = !(op inside {MEM_SB, MEM_SH, MEM_SW});
		return e;
	endfunction

	task automatic add_test(string name, ex_bundle_t e, exc_cause_e cause);
		names.push_back(name);
		stim.push_back(e);
		causes.push_back(cause);
	endtask

	task automatic build_table();
		ex_bundle_t e;
		// Lanes 01, 7F, F1 and 80 give both signs for bytes and halfwords.
		add_test("sw_word", mem_access(MEM_SW, 32'h10, 32'h80F1_7F01), CAUSE_NONE);
		for (int off = 0; off < 4; off++) begin
			add_test($sformatf("lb_off%0d", off),
				mem_access(MEM_LB, 32'h10 + 32'(off), '0), CAUSE_NONE);
			add_test($sformatf("lbu_off%0d", off),
				mem_access(MEM_LBU, 32'h10 + 32'(off), '0), CAUSE_NONE);
		end
		for (int off = 0; off < 4; off += 2) begin
			add_test($sformatf("lh_off%0d", off),
				mem_access(MEM_LH, 32'h10 + 32'(off), '0), CAUSE_NONE);
			add_test($sformatf("lhu_off%0d", off),
				mem_access(MEM_LHU, 32'h10 + 32'(off), '0), CAUSE_NONE);
		end
		add_test("lw_word", mem_access(MEM_LW, 32'h10, '0), CAUSE_NONE);
		add_test("sb_lane1", mem_access(MEM_SB, 32'h21, 32'hFFFF_FF93), CAUSE_NONE);
		add_test("sh_upper", mem_access(MEM_SH, 32'h22, 32'h1234_C5A6), CAUSE_NONE);
		add_test("lw_merged", mem_access(MEM_LW, 32'h20, '0), CAUSE_NONE);
		add_test("lb_merged", mem_access(MEM_LB, 32'h21, '0), CAUSE_NONE);
		add_test("lhu_merged", mem_access(MEM_LHU, 32'h22, '0), CAUSE_NONE);
		// Word 1 aliases 0x404 in the low address bits.
		add_test("sw_range", mem_access(MEM_SW, 32'h404, 32'hDEAD_BEEF), CAUSE_DMEM_BUS_ERROR);
		add_test("lw_range", mem_access(MEM_LW, 32'h404, '0), CAUSE_DMEM_BUS_ERROR);
		add_test("lhu_high", mem_access(MEM_LHU, 32'h8000_0002, '0), CAUSE_DMEM_BUS_ERROR);
		add_test("lw_dropped", mem_access(MEM_LW, 32'h004, '0), CAUSE_NONE);
		add_test("sh_mis", mem_access(MEM_SH, 32'h11, 32'h0000_FFFF), CAUSE_STORE_MISALIGNED);
		add_test("sw_mis", mem_access(MEM_SW, 32'h12, 32'hFFFF_FFFF), CAUSE_STORE_MISALIGNED);
		add_test("lh_mis", mem_access(MEM_LH, 32'h13, '0), CAUSE_LOAD_MISALIGNED);
		add_test("lw_mis", mem_access(MEM_LW, 32'h11, '0), CAUSE_LOAD_MISALIGNED);
		add_test("lw_unchanged", mem_access(MEM_LW, 32'h10, '0), CAUSE_NONE);
		add_test("alu_pass", plain_bundle(SEL_ALU), CAUSE_NONE);
		e = plain_bundle(SEL_CSR);
		e.csr_addr  = 12'h340;
		e.csr_rena  = 1'b1;
		e.csr_wena  = 1'b1;
		e.csr_wdata = 32'hCAFE_F00D;
		e.csr_op    = 2'd1;
		add_test("csr_write", e, CAUSE_NONE);
		e = plain_bundle(SEL_CSR);
		e.csr_addr = 12'h341;
		e.csr_rena = 1'b1;
		add_test("csr_read", e, CAUSE_NONE);
		e = plain_bundle(SEL_FPU);
		e.rd_addr   = 6'd40;
		e.fpu_flags = 5'b10101;
		add_test("fpu_pass", e, CAUSE_NONE);
		e = mem_access(MEM_SW, 32'h10, 32'hFFFF_FFFF);
		e.exc_pend  = 1'b1;
		e.exc_cause = CAUSE_ILLEGAL_INSN;
		add_test("excepted_store", e, CAUSE_ILLEGAL_INSN);
		e = plain_bundle(SEL_PC4);
		e.rd_wena   = 1'b0;
		e.trap_ret  = 1'b1;
		e.exc_pend  = 1'b1;
		e.exc_cause = CAUSE_ECALL_M;
		add_test("ecall_pass", e, CAUSE_ECALL_M);
		add_test("lw_after_pass", mem_access(MEM_LW, 32'h10, '0), CAUSE_NONE);
	endtask

	// Handshakes are sampled at the falling edge, where every input has settled.
	task automatic send_all();
		int i;
		i = 0;
		while (i < n_tests) begin
			ex_valid  = 1'b1;
			ex_bundle = stim[i];
			@(negedge clk);
			if (ex_ready)
				i++;
			@(posedge clk);
			#1;
		end
		ex_valid = 1'b0;
	endtask

	task automatic receive_all();
		int          i;
		logic        stalled;
		mem_bundle_t held;
		mem_bundle_t expected;
		i = 0;
		stalled = 1'b0;
		held = '0;
		while (i < n_tests) begin
			@(negedge clk);
			if (stalled) begin
				if (!out_valid)
					abort_run($sformatf("out_valid dropped before %s was taken.", names[i]));
				else
					check_bundle({names[i], "_stable"}, held, out_bundle);
			end
			stalled = 1'b0;
			if (out_valid && out_ready) begin
				expected = model_step(stim[i]);
				if (stim[i].wb_src == SEL_MEM && stim[i].rd_wena)
					check_word(names[i], expected.rd_data, out_bundle.rd_data);
				check_cause(names[i], causes[i], out_bundle.exc_cause);
				check_bundle(names[i], expected, out_bundle);
				i++;
			end else if (out_valid) begin
				stalled = 1'b1;
				held = out_bundle;
			end
		end
	endtask

	// Write-back takes a bundle in about three cycles out of four.
	initial begin
		out_ready = 1'b0;
		forever begin
			@(posedge clk);
			#1;
			out_ready = random_bit() | random_bit();
		end
	end

	initial begin
		wait (n_tests != 0);
		repeat (16 + 40 * n_tests) @(posedge clk);
		abort_run("Timeout: the bundles did not all come out in the expected time.");
	end

	initial begin
		reset = 1'b1;
		ex_valid = 1'b0;
		ex_bundle = '0;
		for (int i = 0; i < dmem_words; i++)
			model_mem[i] = '0;
		build_table();
		n_tests = names.size();
		repeat (16) @(posedge clk);
		#1;
		reset = 1'b0;
		fork
			send_all();
			receive_all();
		join
		repeat (10) begin
			@(negedge clk);
			if (out_valid)
				abort_run("A bundle came out after the last table entry.");
		end
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- tb.f
cpu_pkg.sv
dmem_bus_pkg.sv
dmem_request.sv
data_ram.sv
mem_stage.sv
mem_subsystem.sv
tb_mem_subsystem.sv

//--- run_sim.sh
#!/bin/sh
# Builds the memory subsystem testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --top-module tb_mem_subsystem --Mdir obj_dir \
	-o sim_mem_subsystem -f tb.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_mem_subsystem > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "ALL CHECKS PASSED" "$LOG"; then
	exit 0
fi
echo "Pass message not found in $LOG"
exit 1
